//--- bench/executeTests.svh
`ifndef EXECUTE_TESTS_SVH
`define EXECUTE_TESTS_SVH

// Reference flags, updated in program order
logic modelC = 1'b0;
logic modelL = 1'b0;
logic modelF = 1'b0;
logic modelZ = 1'b0;
logic modelN = 1'b0;

// Outputs captured in the resultValid cycle
logic [`DATA_WIDTH-1:0] gotData;
logic [`REG_BITS-1:0] gotDest;
logic gotWrite;
logic gotTaken;
logic [`DATA_WIDTH-1:0] gotOffset;

//////////////////////////////////////////////////
// Instruction builders and reference model

function automatic instrWord rTypeWord(aluOp op, logic [3:0] rd, logic [3:0] rs);
	instrWord w;
	w.r.opcode = `OP_RTYPE;
	w.r.rDest = rd;
	w.r.opExt = op;
	w.r.rSrc = rs;
	return w;
endfunction

function automatic instrWord condWord(logic [3:0] opcode, condCode cc, logic [7:0] disp);
	instrWord w;
	w.c.opcode = opcode;
	w.c.cond = cc;
	w.c.disp = disp;
	return w;
endfunction

function automatic logic [15:0] randomWord();
	return 16'($random(seed));
endfunction

// CR16 condition table on the model flags
function automatic logic condModel(condCode cc);
	case (cc)
		EQ: return modelZ;
		NE: return !modelZ;
		CS: return modelC;
		CC: return !modelC;
		HI: return modelL;
		LS: return !modelL;
		GT: return modelN;
		LE: return !modelN;
		FS: return modelF;
		FC: return !modelF;
		LO: return !(modelL || modelZ);  // Below, not equal
		HS: return modelL || modelZ;
		LT: return !(modelN || modelZ);
		GE: return modelN || modelZ;
		UC: return 1'b1;
		default: return 1'b0;  // NV
	endcase
endfunction

// Displacement in halfwords
function automatic logic [15:0] offsetModel(logic [7:0] disp);
	logic signed [15:0] wide;
	wide = $signed(disp);
	return {wide[14:0], 1'b0};
endfunction

task automatic modelAlu(input aluOp op, input logic [15:0] a, input logic [15:0] b,
	output logic [15:0] result);
	int unsigned wideSum;
	int signedVal;  // Exact signed result, range tells overflow
	result = b;
	case (op)
		ADD:
		begin
			wideSum = b + a;
			signedVal = $signed(b) + $signed(a);
			result = wideSum[15:0];
			modelC = wideSum > 32'h0000FFFF;
			modelF = signedVal > 32767 || signedVal < -32768;
		end
		SUB:
		begin
			signedVal = $signed(b) - $signed(a);
			result = b - a;
			modelC = a > b;  // Borrow
			modelF = signedVal > 32767 || signedVal < -32768;
		end
		CMP:
		begin
			modelZ = a == b;
			modelL = a > b;
			modelN = $signed(a) > $signed(b);
		end
		AND: result = b & a;
		OR: result = b | a;
		XOR: result = b ^ a;
		default: result = a;  // MOV
	endcase
endtask

//////////////////////////////////////////////////
// Drive one instruction and collect its result

task automatic issue(input instrWord w, input logic [15:0] a, input logic [15:0] b);
	while (!issueReady)
		@(negedge clk);
	instr = w;
	srcA = a;
	srcB = b;
	instrValid = 1'b1;
	@(negedge clk);  // Accepted at the edge in between
	instrValid = 1'b0;
	while (!resultValid)
		@(negedge clk);
	gotData = resultData;
	gotDest = resultDest;
	gotWrite = resultWrite;
	gotTaken = branchTaken;
	gotOffset = branchOffset;
	creditReturn = 1'b1;  // Consumer takes it, gives the credit back
	@(negedge clk);
	creditReturn = 1'b0;
	checkValue("resultValid", resultValid, 0);  // Single cycle pulse
endtask

task automatic runAlu(input aluOp op, input logic [3:0] rd, input logic [3:0] rs,
	input logic [15:0] a, input logic [15:0] b);
	logic [15:0] expected;
	modelAlu(op, a, b, expected);
	issue(rTypeWord(op, rd, rs), a, b);
	checkValue("resultWrite", gotWrite, op != CMP);
	if (op != CMP)
	begin
		checkValue("resultData", gotData, expected);
		checkValue("resultDest", gotDest, rd);
	end
	checkValue("branchTaken", gotTaken, 0);
endtask

task automatic runScond(input condCode cc, input logic [3:0] rd);
	issue(condWord(`OP_SCOND, cc, {4'h0, rd}), randomWord(), randomWord());
	checkValue("resultWrite", gotWrite, 1);
	checkValue("resultDest", gotDest, rd);
	checkValue("resultData", gotData, {31'b0, condModel(cc)});  // Zero-extended
	checkValue("branchTaken", gotTaken, 0);
endtask

task automatic runBranch(input condCode cc, input logic [7:0] disp);
	issue(condWord(`OP_BCOND, cc, disp), randomWord(), randomWord());
	checkValue("resultWrite", gotWrite, 0);
	checkValue("branchTaken", gotTaken, condModel(cc));
	checkValue("branchOffset", gotOffset, offsetModel(disp));
endtask

//////////////////////////////////////////////////
// Directed tests

task automatic testReset();
	checkValue("issueReady", issueReady, 1);
	checkValue("resultValid", resultValid, 0);
	runScond(EQ, 4'd3);  // Flags all clear
endtask

task automatic testArith();
	int i;
	runAlu(ADD, 4'd1, 4'd2, 16'hFFFF, 16'h0001);  // Carry out
	runScond(CS, 4'd5);
	runScond(FS, 4'd6);
	runAlu(SUB, 4'd1, 4'd2, 16'h0001, 16'h8000);  // Signed overflow
	runScond(CS, 4'd5);
	runScond(FS, 4'd6);
	for (i = 0; i < 5; i++)
	begin
		runAlu(ADD, 4'(i), 4'(i + 7), randomWord(), randomWord());
		runScond(CS, 4'd11);
		runScond(FS, 4'd12);
		runAlu(SUB, 4'(i + 3), 4'(i), randomWord(), randomWord());
		runScond(CS, 4'd13);
		runScond(FS, 4'd14);
	end
endtask

task automatic testCompare();
	int i;
	int cc;
	logic [15:0] a;
	logic [15:0] b;
	for (i = 0; i < 7; i++)
	begin
		a = randomWord();
		b = (i % 3 == 0) ? a : randomWord();  // Some equal pairs
		if (i == 6)
		begin
			a = 16'h8001;  // Unsigned and signed order disagree
			b = 16'h0002;
		end
		runAlu(CMP, 4'd7, 4'd8, a, b);
		for (cc = 0; cc < 16; cc++)
			runScond(condCode'(cc), 4'(cc));
	end
endtask

task automatic testLogic();
	aluOp ops [4];
	int i;
	ops = '{AND, OR, XOR, MOV};
	runAlu(ADD, 4'd1, 4'd2, 16'hFFFF, 16'h0002);  // C set
	runAlu(CMP, 4'd1, 4'd2, 16'h0005, 16'h0005);  // Z set
	for (i = 0; i < 4; i++)
	begin
		runAlu(ops[i], 4'd9, 4'd10, randomWord(), randomWord());
		runScond(CS, 4'd1);
		runScond(EQ, 4'd2);
	end
endtask

task automatic testBackPressure();
	logic [15:0] expected [4];
	int i;
	for (i = 0; i < 4; i++)
	begin
		expected[i] = randomWord();
		checkValue("issueReady", issueReady, 1);
		instr = rTypeWord(MOV, 4'(i), 4'd0);
		srcA = expected[i];
		srcB = '0;
		instrValid = 1'b1;
		@(negedge clk);
		// Result i comes out while the next one is offered
		checkValue("resultValid", resultValid, 1);
		checkValue("resultData", resultData, expected[i]);
		checkValue("resultDest", resultDest, i);
	end
	instr = rTypeWord(MOV, 4'd4, 4'd0);  // Fifth one stalls
	srcA = 16'hDEAD;
	repeat (3)
	begin
		checkValue("issueReady", issueReady, 0);
		@(negedge clk);
		checkValue("resultValid", resultValid, 0);
	end
	instrValid = 1'b0;
	creditReturn = 1'b1;
	@(negedge clk);
	creditReturn = 1'b0;
	checkValue("issueReady", issueReady, 1);
	creditReturn = 1'b1;  // Remaining three credits
	repeat (3)
		@(negedge clk);
	creditReturn = 1'b0;
endtask

task automatic testBranch();
	runAlu(CMP, 4'd0, 4'd1, 16'h1234, 16'h1234);  // Z only
	runBranch(EQ, 8'hF6);  // Taken, backward
	runBranch(NE, 8'h12);  // Not taken, forward
	runBranch(UC, 8'h80);
	runBranch(NV, 8'h7F);
	runAlu(CMP, 4'd0, 4'd1, 16'h0003, 16'h0001);
	runBranch(HI, 8'h40);
	runBranch(LO, 8'hC1);
endtask

`endif

//--- bench/executeCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cr16_consts.svh"

module executeCoreTb;
	import instrPkg::*;
	import flagsPkg::*;

	localparam int clockPeriod = 40;
	localparam int cycleLimit = 2000;  // Whole run needs roughly 400 cycles

	logic clk;
	logic reset;
	instrWord instr;
	logic [`DATA_WIDTH-1:0] srcA;  // rSrc value
	logic [`DATA_WIDTH-1:0] srcB;  // rDest value
	logic instrValid;
	logic creditReturn;
	logic issueReady;
	logic resultValid;
	logic [`DATA_WIDTH-1:0] resultData;
	logic [`REG_BITS-1:0] resultDest;
	logic resultWrite;
	logic branchTaken;
	logic [`DATA_WIDTH-1:0] branchOffset;

	integer seed;  // Shared by all random operands

	executeCore DUT (
		.clk(clk), .reset(reset), .instr(instr), .srcA(srcA), .srcB(srcB),
		.instrValid(instrValid), .creditReturn(creditReturn),
		.issueReady(issueReady), .resultValid(resultValid), .resultData(resultData),
		.resultDest(resultDest), .resultWrite(resultWrite), .branchTaken(branchTaken),
		.branchOffset(branchOffset)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clockPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Failure reporting

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			reportFailure($sformatf("CHECK FAILED at %0t: %s got %0h, expected %0h",
				$time, name, got, expected));
	endtask

	`include "executeTests.svh"

	// Watchdog, ends a hung run
	initial
	begin
		repeat (cycleLimit)
			@(posedge clk);
		reportFailure("Timeout, the tests did not finish within the cycle limit");
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		seed = 78747;
		reset = 1'b1;
		instr = '0;
		srcA = '0;
		srcB = '0;
		instrValid = 1'b0;
		creditReturn = 1'b0;
		repeat (5)
			@(posedge clk);
		@(negedge clk);  // Release away from the active edge
		reset = 1'b0;

		testReset();
		testArith();
		testCompare();
		testLogic();
		testBackPressure();
		testBranch();

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cr16_consts.svh"

module aluUnit (
	input wire clk,
	input wire reset,
	input wire instrAccept,
	input wire instrPkg::instrWord instr,
	input wire [`DATA_WIDTH-1:0] srcA,  // rSrc value
	input wire [`DATA_WIDTH-1:0] srcB,  // rDest value
	output logic [`DATA_WIDTH-1:0] aluResult,
	output logic [`REG_BITS-1:0] aluDest,
	output logic aluWrite,
	output logic [`FLAG_BITS-1:0] flagNext,
	output logic carryWrite,    // Loads C and F
	output logic compareWrite   // Loads L, Z and N
);
	import instrPkg::*;
	import flagsPkg::*;

	localparam int msb = `DATA_WIDTH - 1;

	logic isRType;
	logic [`DATA_WIDTH:0] sum;   // Carry out in top bit
	logic [`DATA_WIDTH:0] diff;  // Borrow in top bit
	logic addOverflow;
	logic subOverflow;
	logic [`DATA_WIDTH-1:0] resultNext;
	logic writeNext;

	assign isRType = instr.r.opcode == `OP_RTYPE;

	// Both arithmetic paths always built
	assign sum = {1'b0, srcB} + {1'b0, srcA};
	assign diff = {1'b0, srcB} - {1'b0, srcA};
	assign addOverflow = (srcA[msb] == srcB[msb]) && (sum[msb] != srcB[msb]);
	assign subOverflow = (srcA[msb] != srcB[msb]) && (diff[msb] != srcB[msb]);

	//////////////////////////////////////////////////
	// Operation decode

	always_comb
	begin
		resultNext = srcB;
		writeNext = 1'b0;
		flagNext = '0;  // Unused bits stay clear
		case (instr.r.opExt)
			ADD:
			begin
				resultNext = sum[msb:0];
				writeNext = 1'b1;
				flagNext[FLAG_C] = sum[`DATA_WIDTH];
				flagNext[FLAG_F] = addOverflow;
			end
			SUB:
			begin
				resultNext = diff[msb:0];  // rDest - rSrc
				writeNext = 1'b1;
				flagNext[FLAG_C] = diff[`DATA_WIDTH];
				flagNext[FLAG_F] = subOverflow;
			end
			CMP:
			begin
				flagNext[FLAG_Z] = srcA == srcB;
				flagNext[FLAG_L] = srcA > srcB;
				flagNext[FLAG_N] = $signed(srcA) > $signed(srcB);
			end
			AND:
			begin
				resultNext = srcB & srcA;
				writeNext = 1'b1;
			end
			OR:
			begin
				resultNext = srcB | srcA;
				writeNext = 1'b1;
			end
			XOR:
			begin
				resultNext = srcB ^ srcA;
				writeNext = 1'b1;
			end
			MOV:
			begin
				resultNext = srcA;
				writeNext = 1'b1;
			end
			default: writeNext = 1'b0;  // Unknown ext has no effect
		endcase
	end

	// Flag group enables only on an accepted R-type
	assign carryWrite = instrAccept && isRType && (instr.r.opExt inside {ADD, SUB});
	assign compareWrite = instrAccept && isRType && (instr.r.opExt == CMP);

	//////////////////////////////////////////////////
	// Result register loaded at accept

	always_ff @(posedge clk)
	begin
		if (reset)
			aluWrite <= 1'b0;
		else if (instrAccept)
			aluWrite <= isRType && writeNext;
	end

	always_ff @(posedge clk)
	begin
		if (instrAccept)
		begin
			aluResult <= resultNext;
			aluDest <= instr.r.rDest;
		end
	end

	// A compare never reaches the register file
	compareNoWrite: assert property (@(posedge clk) disable iff (reset)
		compareWrite |=> !aluWrite);

endmodule

`default_nettype wire

//--- logic/cr16_consts.svh
`ifndef CR16_CONSTS_SVH
`define CR16_CONSTS_SVH

// Datapath sizes
`define DATA_WIDTH 16
`define REG_BITS 4      // 16 general registers
`define COND_BITS 4     // Scond / Bcond condition field
`define OPCODE_BITS 4   // Major opcode in [15:12]
`define DISP_BITS 8     // Bcond displacement, Scond dest in low bits
`define FLAG_BITS 5     // {C, L, F, Z, N}

// Output link depth, in credits
`define RESULT_CREDITS 4

// Major opcodes
`define OP_RTYPE 4'b0000  // Register-register ALU ops
`define OP_SCOND 4'b0100  // Set register from condition
`define OP_BCOND 4'b1100  // Conditional branch

`endif

//--- logic/executeCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "cr16_consts.svh"

module executeCore (
	input wire clk,
	input wire reset,
	input wire instrPkg::instrWord instr,
	input wire [`DATA_WIDTH-1:0] srcA,
	input wire [`DATA_WIDTH-1:0] srcB,
	input wire instrValid,
	input wire creditReturn,
	output logic issueReady,
	output logic resultValid,
	output logic [`DATA_WIDTH-1:0] resultData,
	output logic [`REG_BITS-1:0] resultDest,
	output logic resultWrite,
	output logic branchTaken,
	output logic [`DATA_WIDTH-1:0] branchOffset
);
	// ALU to PSR and output stage
	logic instrAccept;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`REG_BITS-1:0] aluDest;
	logic aluWrite;
	logic [`FLAG_BITS-1:0] flagNext;
	logic carryWrite;
	logic compareWrite;
	logic condMet;

	aluUnit alu (
		.clk(clk), .reset(reset), .instrAccept(instrAccept), .instr(instr),
		.srcA(srcA), .srcB(srcB),
		.aluResult(aluResult), .aluDest(aluDest), .aluWrite(aluWrite),
		.flagNext(flagNext), .carryWrite(carryWrite), .compareWrite(compareWrite)
	);

	programStatusRegister psr (
		.clk(clk), .reset(reset), .instrAccept(instrAccept), .instr(instr),
		.flagNext(flagNext), .carryWrite(carryWrite), .compareWrite(compareWrite),
		.condMet(condMet)
	);

	resultSelect sel (
		.clk(clk), .reset(reset), .instrValid(instrValid), .creditReturn(creditReturn),
		.instr(instr), .aluResult(aluResult), .aluDest(aluDest), .aluWrite(aluWrite),
		.condMet(condMet), .issueReady(issueReady), .instrAccept(instrAccept),
		.resultValid(resultValid), .resultWrite(resultWrite), .branchTaken(branchTaken),
		.resultData(resultData), .branchOffset(branchOffset), .resultDest(resultDest)
	);

endmodule

`default_nettype wire

//--- logic/flagsPkg.sv
`default_nettype none

package flagsPkg;

	// Bit positions in the flag vector {C, L, F, Z, N}
	typedef enum int unsigned {
		FLAG_N = 0,  // Signed greater, from CMP
		FLAG_Z = 1,  // Equal, from CMP
		FLAG_F = 2,  // Signed overflow, from ADD/SUB
		FLAG_L = 3,  // Unsigned greater, from CMP
		FLAG_C = 4   // Carry or borrow, from ADD/SUB
	} flagIndex;

	// Condition field encoding
	typedef enum logic [3:0] {
		EQ = 4'd0, NE = 4'd1, CS = 4'd2, CC = 4'd3,
		HI = 4'd4, LS = 4'd5, GT = 4'd6, LE = 4'd7,
		FS = 4'd8, FC = 4'd9, LO = 4'd10, HS = 4'd11,
		LT = 4'd12, GE = 4'd13,
		UC = 4'd14,  // Always
		NV = 4'd15   // Never
	} condCode;

endpackage

`default_nettype wire

//--- logic/instrPkg.sv
`default_nettype none

`include "cr16_consts.svh"

package instrPkg;

	// ALU operation, R-type extension field [7:4]
	typedef enum logic [3:0] {
		AND = 4'b0001,
		OR  = 4'b0010,
		XOR = 4'b0011,
		ADD = 4'b0101,
		SUB = 4'b1001,
		CMP = 4'b1011,  // Flags only, no register write
		MOV = 4'b1101
	} aluOp;

	// Register-register format
	typedef struct packed {
		logic [`OPCODE_BITS-1:0] opcode;
		logic [`REG_BITS-1:0] rDest;  // Also second operand
		aluOp opExt;
		logic [`REG_BITS-1:0] rSrc;
	} rTypeFields;

	// Scond / Bcond format
	typedef struct packed {
		logic [`OPCODE_BITS-1:0] opcode;
		logic [`COND_BITS-1:0] cond;
		logic [`DISP_BITS-1:0] disp;  // Branch disp, or Scond dest in [3:0]
	} condTypeFields;

	// Same 16 bits seen through either format
	typedef union packed {
		rTypeFields r;
		condTypeFields c;
	} instrWord;

endpackage

`default_nettype wire

//--- logic/programStatusRegister.sv
`timescale 1ns/1ps
`default_nettype none

`include "cr16_consts.svh"

module programStatusRegister (
	input wire clk,
	input wire reset,
	input wire instrAccept,
	input wire instrPkg::instrWord instr,
	input wire [`FLAG_BITS-1:0] flagNext,
	input wire carryWrite,
	input wire compareWrite,
	output logic condMet  // Registered at accept
);
	import flagsPkg::*;

	logic [`FLAG_BITS-1:0] flags;  // {C, L, F, Z, N}
	condCode cond;
	logic condNow;
	logic c;
	logic l;
	logic f;
	logic z;
	logic n;

	assign cond = condCode'(instr.c.cond);

	//////////////////////////////////////////////////
	// Flag register, two independent groups

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
		begin
			if (carryWrite)
			begin
				flags[FLAG_C] <= flagNext[FLAG_C];
				flags[FLAG_F] <= flagNext[FLAG_F];
			end
			if (compareWrite)  // Same cycle as carryWrite is allowed
			begin
				flags[FLAG_L] <= flagNext[FLAG_L];
				flags[FLAG_Z] <= flagNext[FLAG_Z];
				flags[FLAG_N] <= flagNext[FLAG_N];
			end
		end
	end

	assign c = flags[FLAG_C];
	assign l = flags[FLAG_L];
	assign f = flags[FLAG_F];
	assign z = flags[FLAG_Z];
	assign n = flags[FLAG_N];

	//////////////////////////////////////////////////
	// Condition table, current flags only

	always_comb
	begin
		case (cond)
			EQ: condNow = z;
			NE: condNow = !z;
			CS: condNow = c;
			CC: condNow = !c;
			HI: condNow = l;
			LS: condNow = !l;
			GT: condNow = n;
			LE: condNow = !n;
			FS: condNow = f;
			FC: condNow = !f;
			LO: condNow = !l && !z;
			HS: condNow = l || z;
			LT: condNow = !n && !z;
			GE: condNow = n || z;
			UC: condNow = 1'b1;  // Branch always taken
			default: condNow = 1'b0;  // NV
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			condMet <= 1'b0;
		else if (instrAccept)
			condMet <= condNow;
	end

endmodule

`default_nettype wire

//--- logic/resultSelect.sv
`timescale 1ns/1ps
`default_nettype none

`include "cr16_consts.svh"

module resultSelect (
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire creditReturn,  // One credit back per pulse
	input wire instrPkg::instrWord instr,
	input wire [`DATA_WIDTH-1:0] aluResult,
	input wire [`REG_BITS-1:0] aluDest,
	input wire aluWrite,
	input wire condMet,
	output logic issueReady,
	output logic instrAccept,
	output logic resultValid,
	output logic resultWrite,
	output logic branchTaken,
	output logic [`DATA_WIDTH-1:0] resultData,
	output logic [`DATA_WIDTH-1:0] branchOffset,
	output logic [`REG_BITS-1:0] resultDest
);
	localparam int creditBits = $clog2(`RESULT_CREDITS + 1);

	logic [creditBits-1:0] creditCount;
	logic [`OPCODE_BITS-1:0] opReg;  // Kind of the issued instruction
	logic [`DISP_BITS-1:0] dispReg;
	logic isRType;
	logic isScond;
	logic isBcond;

	//////////////////////////////////////////////////
	// Credits and accept

	assign issueReady = creditCount != '0;
	assign instrAccept = instrValid && issueReady;

	always_ff @(posedge clk)
	begin
		if (reset)
			creditCount <= creditBits'(`RESULT_CREDITS);
		else
			case ({instrAccept, creditReturn})
				2'b10: creditCount <= creditCount - 1'b1;  // Spend
				2'b01: creditCount <= creditCount + 1'b1;  // Refill
				default: creditCount <= creditCount;  // Both or neither
			endcase
	end

	// Issued kind and the result valid pulse
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			opReg <= `OP_RTYPE;
		end
		else
		begin
			resultValid <= instrAccept;  // One cycle pulse per accept
			if (instrAccept)
				opReg <= instr.c.opcode;
		end
	end

	always_ff @(posedge clk)
	begin
		if (instrAccept)
			dispReg <= instr.c.disp;
	end

	//////////////////////////////////////////////////
	// Output merge

	assign isRType = opReg == `OP_RTYPE;
	assign isScond = opReg == `OP_SCOND;
	assign isBcond = opReg == `OP_BCOND;

	assign resultData = isScond ? {{(`DATA_WIDTH - 1){1'b0}}, condMet} : aluResult;
	assign resultDest = isScond ? dispReg[`REG_BITS-1:0] : aluDest;
	assign resultWrite = resultValid && (isRType ? aluWrite : isScond);
	assign branchTaken = resultValid && isBcond && condMet;
	// Sign-extended halfword displacement
	assign branchOffset = {{(`DATA_WIDTH - `DISP_BITS - 1){dispReg[`DISP_BITS-1]}}, dispReg, 1'b0};

	// Consumer never returns more than it was given
	creditNoOverflow: assert property (@(posedge clk) disable iff (reset)
		(creditReturn && !instrAccept) |-> creditCount < `RESULT_CREDITS);

	// Empty and no refill means no accept next cycle
	noAcceptWhenEmpty: assert property (@(posedge clk) disable iff (reset)
		(creditCount == '0 && !creditReturn) |=> !instrAccept);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the execute slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module executeCoreTb -Mdir obj_dir -o executeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/executeSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi
echo "Simulation finished cleanly"
exit 0

//--- verilog.f
+incdir+logic
+incdir+bench
logic/flagsPkg.sv
logic/instrPkg.sv
logic/aluUnit.sv
logic/programStatusRegister.sv
logic/resultSelect.sv
logic/executeCore.sv
bench/executeCoreTb.sv
